// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module tb_i2s_rx
	./obj_dir/Vtb_i2s_rx > sim.log 2>&1 || (cat sim.log; false)
	cat sim.log
	! grep -q "FAIL: see errors above" sim.log

clean:
	rm -rf obj_dir sim.log

// File: src.f
+incdir+src
src/i2s_rx_pkg.sv
src/i2s_deserializer.sv
src/sample_fifo.sv
src/dma_sequencer.sv
src/i2s_rx_regs.sv
src/i2s_rx_dma_top.sv
verification/i2s_rx_checker.sv
verification/tb_i2s_rx.sv

// File: src/dma_sequencer.sv
`timescale 1ns/1ps

module dma_sequencer (
	input  logic                   wbs_clk_i,
	input  logic                   rst_i,
	input  logic                   start_i,
	input  i2s_rx_pkg::dma_count_t count_i,
	input  logic                   pop_i,
	input  logic                   pair_ready_i,
	output logic                   sdma_req_o,
	output logic                   busy_o,
	output i2s_rx_pkg::dma_state_e state_o,
	output logic                   done_o
);

	i2s_rx_pkg::dma_state_e state_q;
	i2s_rx_pkg::dma_count_t remaining_q;

	// ------------------------------
	// Request FSM
	// ------------------------------
	always_ff @(posedge wbs_clk_i) begin
		if (rst_i) begin
			state_q     <= i2s_rx_pkg::DMA_IDLE;
			remaining_q <= '0;
			done_o      <= 1'b0;
		end else begin
			done_o <= 1'b0;
			unique case (state_q)
				i2s_rx_pkg::DMA_IDLE: begin
					// Zero count start is dropped
					if (start_i && count_i != '0) begin
						remaining_q <= count_i;
						state_q     <= i2s_rx_pkg::DMA_WAIT;
					end
				end
				i2s_rx_pkg::DMA_WAIT,
				i2s_rx_pkg::DMA_REQ: begin
					if (pop_i && remaining_q == i2s_rx_pkg::dma_count_t'(1)) begin
						remaining_q <= '0;
						state_q     <= i2s_rx_pkg::DMA_IDLE;
						done_o      <= 1'b1;   // Last pair taken
					end else begin
						if (pop_i)
							remaining_q <= remaining_q - 1'b1;
						// Follow pair availability
						state_q <= pair_ready_i ? i2s_rx_pkg::DMA_REQ
						                        : i2s_rx_pkg::DMA_WAIT;
					end
				end
				default: state_q <= i2s_rx_pkg::DMA_IDLE;
			endcase
		end
	end

	assign sdma_req_o = (state_q == i2s_rx_pkg::DMA_REQ);
	assign busy_o     = (state_q != i2s_rx_pkg::DMA_IDLE);
	assign state_o    = state_q;

endmodule

// File: src/i2s_deserializer.sv
`timescale 1ns/1ps
`include "i2s_rx_params.svh"

module i2s_deserializer (
	input  logic                wbs_clk_i,
	input  logic                rst_i,
	input  logic                rx_en_i,
	input  logic                i2s_sck_i,
	input  logic                i2s_ws_i,
	input  logic                i2s_din_i,
	output i2s_rx_pkg::sample_t sample_o,
	output logic                push_left_o,
	output logic                push_right_o
);

	localparam int CNT_W = $clog2(`I2S_SAMPLE_W + 1);

	logic [2:0]          sck_sync;   // Two sync stages plus one for the edge
	logic [1:0]          ws_sync;
	logic [1:0]          din_sync;
	logic                sck_rise;
	logic                ws_prev;
	logic                chan_right;
	logic [CNT_W-1:0]    bits_left;
	i2s_rx_pkg::sample_t shift_q;

	// ------------------------------
	// Pin synchronizers
	// ------------------------------
	always_ff @(posedge wbs_clk_i) begin
		if (rst_i) begin
			sck_sync <= '0;
			ws_sync  <= '0;
			din_sync <= '0;
		end else begin
			sck_sync <= {sck_sync[1:0], i2s_sck_i};
			ws_sync  <= {ws_sync[0], i2s_ws_i};
			din_sync <= {din_sync[0], i2s_din_i};
		end
	end

	assign sck_rise = sck_sync[1] & ~sck_sync[2];

	// ------------------------------
	// Word framing
	// ------------------------------
	always_ff @(posedge wbs_clk_i) begin
		if (rst_i) begin
			ws_prev      <= 1'b0;
			chan_right   <= 1'b0;
			bits_left    <= '0;
			push_left_o  <= 1'b0;
			push_right_o <= 1'b0;
		end else begin
			push_left_o  <= 1'b0;
			push_right_o <= 1'b0;
			if (sck_rise)
				ws_prev <= ws_sync[1];   // Tracked even while disabled

			if (!rx_en_i) begin
				bits_left <= '0;
			end else if (sck_rise) begin
				if (ws_sync[1] != ws_prev) begin
					// Channel switch, MSB arrives on the next edge
					bits_left  <= CNT_W'(`I2S_SAMPLE_W);
					chan_right <= ws_sync[1];
				end else if (bits_left != '0) begin
					bits_left <= bits_left - 1'b1;
					if (bits_left == CNT_W'(1)) begin
						push_left_o  <= ~chan_right;
						push_right_o <= chan_right;
					end
				end
			end
		end
	end

	// MSB first shift register
	always_ff @(posedge wbs_clk_i) begin
		if (sck_rise && bits_left != '0 && ws_sync[1] == ws_prev)
			shift_q <= {shift_q[`I2S_SAMPLE_W-2:0], din_sync[1]};
	end

	assign sample_o = shift_q;   // Complete word during the push strobe

endmodule

// File: src/i2s_rx_dma_top.sv
`timescale 1ns/1ps

module i2s_rx_dma_top (
	input  logic                  wbs_clk_i,
	input  logic                  rst_i,
	input  i2s_rx_pkg::reg_addr_t wbs_adr_i,
	input  logic                  wbs_cyc_i,
	input  logic                  wbs_stb_i,
	input  logic                  wbs_we_i,
	input  i2s_rx_pkg::wb_data_t  wbs_dat_i,
	output i2s_rx_pkg::wb_data_t  wbs_dat_o,
	output logic                  wbs_ack_o,
	input  logic                  i2s_sck_i,
	input  logic                  i2s_ws_i,
	input  logic                  i2s_din_i,
	output logic                  irq_data_o,
	output logic                  irq_dma_o,
	output logic                  sdma_req_o
);

	// Receiver to FIFOs
	i2s_rx_pkg::sample_t    sample;
	logic                   push_left;
	logic                   push_right;

	// FIFO status and pops
	i2s_rx_pkg::sample_t    l_data, r_data;
	logic                   l_empty, r_empty;
	logic                   l_full, r_full;
	i2s_rx_pkg::level_t     l_level, r_level;
	logic                   l_pop, r_pop;

	// Control and DMA
	logic                   rx_en;
	logic                   flush;
	logic                   dma_start;
	i2s_rx_pkg::dma_count_t dma_count;
	logic                   dma_pop;
	logic                   dma_busy;
	i2s_rx_pkg::dma_state_e dma_state;
	logic                   dma_done;
	logic                   pair_ready;

	assign pair_ready = ~l_empty & ~r_empty;   // One stereo pair waiting

	i2s_deserializer u_deserializer (
		.wbs_clk_i(wbs_clk_i), .rst_i(rst_i), .rx_en_i(rx_en),
		.i2s_sck_i(i2s_sck_i), .i2s_ws_i(i2s_ws_i), .i2s_din_i(i2s_din_i),
		.sample_o(sample), .push_left_o(push_left), .push_right_o(push_right)
	);

	sample_fifo u_left_fifo (
		.wbs_clk_i(wbs_clk_i), .rst_i(rst_i), .flush_i(flush),
		.push_i(push_left), .data_i(sample), .pop_i(l_pop),
		.data_o(l_data), .empty_o(l_empty), .full_o(l_full), .level_o(l_level)
	);

	sample_fifo u_right_fifo (
		.wbs_clk_i(wbs_clk_i), .rst_i(rst_i), .flush_i(flush),
		.push_i(push_right), .data_i(sample), .pop_i(r_pop),
		.data_o(r_data), .empty_o(r_empty), .full_o(r_full), .level_o(r_level)
	);

	dma_sequencer u_dma_sequencer (
		.wbs_clk_i(wbs_clk_i), .rst_i(rst_i), .start_i(dma_start),
		.count_i(dma_count), .pop_i(dma_pop), .pair_ready_i(pair_ready),
		.sdma_req_o(sdma_req_o), .busy_o(dma_busy), .state_o(dma_state), .done_o(dma_done)
	);

	i2s_rx_regs u_regs (
		.wbs_clk_i(wbs_clk_i), .rst_i(rst_i), .wbs_adr_i(wbs_adr_i),
		.wbs_cyc_i(wbs_cyc_i), .wbs_stb_i(wbs_stb_i), .wbs_we_i(wbs_we_i),
		.wbs_dat_i(wbs_dat_i), .wbs_dat_o(wbs_dat_o), .wbs_ack_o(wbs_ack_o),
		.rx_en_o(rx_en), .flush_o(flush),
		.l_data_i(l_data), .l_empty_i(l_empty), .l_full_i(l_full), .l_level_i(l_level),
		.r_data_i(r_data), .r_empty_i(r_empty), .r_full_i(r_full), .r_level_i(r_level),
		.l_pop_o(l_pop), .r_pop_o(r_pop),
		.dma_start_o(dma_start), .dma_count_o(dma_count), .dma_pop_o(dma_pop),
		.dma_busy_i(dma_busy), .dma_state_i(dma_state), .dma_done_i(dma_done),
		.irq_data_o(irq_data_o), .irq_dma_o(irq_dma_o)
	);

endmodule

// File: src/i2s_rx_params.svh
`ifndef I2S_RX_PARAMS_SVH
`define I2S_RX_PARAMS_SVH

// ------------------------------
// Sample path sizing
// ------------------------------
`define I2S_SAMPLE_W      16
`define I2S_FIFO_DEPTH    16
`define I2S_LEVEL_W       5
`define I2S_IRQ_LEVEL     8      // Fill level that flags a data interrupt

// Bus and DMA widths
`define WB_ADDR_W         9
`define WB_DATA_W         32
`define DMA_COUNT_W       9

`define I2S_UNDEF_VALUE   32'hDADDEFAC   // Marks a read of an unmapped word

// ------------------------------
// Register map, word addresses
// ------------------------------
`define REG_EN            9'h000
`define REG_FLUSH         9'h001
`define REG_IRQ_STS       9'h002
`define REG_IRQ_EN        9'h003
`define REG_LSTS          9'h004
`define REG_RSTS          9'h005
`define REG_LDAT          9'h006
`define REG_RDAT          9'h007
`define REG_DMA_START     9'h008
`define REG_DMA_STS       9'h009
`define REG_DMA_CNT       9'h00A
`define REG_DMA_DAT       9'h00B

`endif

// File: src/i2s_rx_pkg.sv
`include "i2s_rx_params.svh"

package i2s_rx_pkg;

	// Audio and FIFO bookkeeping
	typedef logic [`I2S_SAMPLE_W-1:0] sample_t;
	typedef logic [`I2S_LEVEL_W-1:0]  level_t;     // 0 up to full depth

	// Bus side
	typedef logic [`WB_ADDR_W-1:0]    reg_addr_t;
	typedef logic [`WB_DATA_W-1:0]    wb_data_t;

	typedef logic [`DMA_COUNT_W-1:0]  dma_count_t; // Stereo pairs left to move

	// DMA request sequencer
	typedef enum logic [1:0] {
		DMA_IDLE = 2'd0,
		DMA_WAIT = 2'd1,   // Armed, no pair ready yet
		DMA_REQ  = 2'd2
	} dma_state_e;

endpackage

// File: src/i2s_rx_regs.sv
`timescale 1ns/1ps
`include "i2s_rx_params.svh"

module i2s_rx_regs (
	input  logic                   wbs_clk_i,
	input  logic                   rst_i,
	input  i2s_rx_pkg::reg_addr_t  wbs_adr_i,
	input  logic                   wbs_cyc_i,
	input  logic                   wbs_stb_i,
	input  logic                   wbs_we_i,
	input  i2s_rx_pkg::wb_data_t   wbs_dat_i,
	output i2s_rx_pkg::wb_data_t   wbs_dat_o,
	output logic                   wbs_ack_o,
	output logic                   rx_en_o,
	output logic                   flush_o,
	input  i2s_rx_pkg::sample_t    l_data_i,
	input  logic                   l_empty_i,
	input  logic                   l_full_i,
	input  i2s_rx_pkg::level_t     l_level_i,
	input  i2s_rx_pkg::sample_t    r_data_i,
	input  logic                   r_empty_i,
	input  logic                   r_full_i,
	input  i2s_rx_pkg::level_t     r_level_i,
	output logic                   l_pop_o,
	output logic                   r_pop_o,
	output logic                   dma_start_o,
	output i2s_rx_pkg::dma_count_t dma_count_o,
	output logic                   dma_pop_o,
	input  logic                   dma_busy_i,
	input  i2s_rx_pkg::dma_state_e dma_state_i,
	input  logic                   dma_done_i,
	output logic                   irq_data_o,
	output logic                   irq_dma_o
);

	localparam i2s_rx_pkg::level_t IRQ_LEVEL = i2s_rx_pkg::level_t'(`I2S_IRQ_LEVEL);

	logic                   bus_req;
	logic                   wr_req;
	logic                   rd_req;
	logic                   pair_avail;
	logic                   l_irq;
	logic                   r_irq;
	logic                   done_sts;
	logic [2:0]             irq_en_q;
	i2s_rx_pkg::dma_count_t dma_cnt_q;
	i2s_rx_pkg::wb_data_t   rd_data;

	// One request per access, ack blocks the repeat
	assign bus_req    = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;
	assign wr_req     = bus_req & wbs_we_i;
	assign rd_req     = bus_req & ~wbs_we_i;
	assign pair_avail = ~l_empty_i & ~r_empty_i;

	// ------------------------------
	// Strobes toward the datapath
	// ------------------------------
	assign flush_o     = wr_req & (wbs_adr_i == `REG_FLUSH) & wbs_dat_i[0];
	assign dma_start_o = wr_req & (wbs_adr_i == `REG_DMA_START) & wbs_dat_i[0];
	assign dma_pop_o   = rd_req & (wbs_adr_i == `REG_DMA_DAT) & pair_avail;
	assign l_pop_o     = (rd_req & (wbs_adr_i == `REG_LDAT) & ~l_empty_i) | dma_pop_o;
	assign r_pop_o     = (rd_req & (wbs_adr_i == `REG_RDAT) & ~r_empty_i) | dma_pop_o;
	assign dma_count_o = dma_cnt_q;

	// Control registers and sticky status
	always_ff @(posedge wbs_clk_i) begin
		if (rst_i) begin
			wbs_ack_o <= 1'b0;
			rx_en_o   <= 1'b0;
			irq_en_q  <= '0;
			dma_cnt_q <= '0;
			done_sts  <= 1'b0;
		end else begin
			wbs_ack_o <= bus_req;
			if (wr_req) begin
				case (wbs_adr_i)
					`REG_EN:      rx_en_o   <= wbs_dat_i[0];
					`REG_IRQ_EN:  irq_en_q  <= wbs_dat_i[2:0];
					`REG_DMA_CNT: dma_cnt_q <= wbs_dat_i[`DMA_COUNT_W-1:0];
					default: ;
				endcase
			end
			if (dma_done_i)
				done_sts <= 1'b1;   // Set wins over a clear
			else if (wr_req && wbs_adr_i == `REG_IRQ_STS && wbs_dat_i[2])
				done_sts <= 1'b0;
		end
	end

	// ------------------------------
	// Read path
	// ------------------------------
	always_comb begin
		unique case (wbs_adr_i)
			`REG_EN:        rd_data = i2s_rx_pkg::wb_data_t'(rx_en_o);
			`REG_FLUSH:     rd_data = '0;
			`REG_IRQ_STS:   rd_data = i2s_rx_pkg::wb_data_t'({done_sts, r_irq, l_irq});
			`REG_IRQ_EN:    rd_data = i2s_rx_pkg::wb_data_t'(irq_en_q);
			`REG_LSTS:      rd_data = i2s_rx_pkg::wb_data_t'({l_level_i, l_full_i, l_empty_i});
			`REG_RSTS:      rd_data = i2s_rx_pkg::wb_data_t'({r_level_i, r_full_i, r_empty_i});
			`REG_LDAT:      rd_data = l_empty_i ? '0 : i2s_rx_pkg::wb_data_t'(l_data_i);
			`REG_RDAT:      rd_data = r_empty_i ? '0 : i2s_rx_pkg::wb_data_t'(r_data_i);
			`REG_DMA_START: rd_data = '0;
			`REG_DMA_STS:   rd_data = i2s_rx_pkg::wb_data_t'({dma_state_i, dma_busy_i});
			`REG_DMA_CNT:   rd_data = i2s_rx_pkg::wb_data_t'(dma_cnt_q);
			`REG_DMA_DAT:   rd_data = pair_avail ? {r_data_i, l_data_i} : '0; // Right high
			default:        rd_data = `I2S_UNDEF_VALUE;
		endcase
	end

	// Captured at the request edge, held through ack
	always_ff @(posedge wbs_clk_i) begin
		if (rd_req)
			wbs_dat_o <= rd_data;
	end

	// Interrupt outputs
	assign l_irq      = (l_level_i >= IRQ_LEVEL);
	assign r_irq      = (r_level_i >= IRQ_LEVEL);
	assign irq_data_o = (l_irq & irq_en_q[0]) | (r_irq & irq_en_q[1]);
	assign irq_dma_o  = done_sts & irq_en_q[2];

endmodule

// File: src/sample_fifo.sv
`timescale 1ns/1ps
`include "i2s_rx_params.svh"

module sample_fifo (
	input  logic                wbs_clk_i,
	input  logic                rst_i,
	input  logic                flush_i,
	input  logic                push_i,
	input  i2s_rx_pkg::sample_t data_i,
	input  logic                pop_i,
	output i2s_rx_pkg::sample_t data_o,
	output logic                empty_o,
	output logic                full_o,
	output i2s_rx_pkg::level_t  level_o
);

	localparam int PTR_W = $clog2(`I2S_FIFO_DEPTH);
	localparam i2s_rx_pkg::level_t FULL_LEVEL = i2s_rx_pkg::level_t'(`I2S_FIFO_DEPTH);

	i2s_rx_pkg::sample_t mem [`I2S_FIFO_DEPTH];
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	i2s_rx_pkg::level_t  level_q;
	logic                do_push;
	logic                do_pop;

	assign do_push = push_i & ~full_o;    // Overflow drops the word
	assign do_pop  = pop_i & ~empty_o;

	// Pointers and level
	always_ff @(posedge wbs_clk_i) begin
		if (rst_i || flush_i) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			level_q <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				level_q <= level_q + 1'b1;
			else if (do_pop && !do_push)
				level_q <= level_q - 1'b1;
		end
	end

	always_ff @(posedge wbs_clk_i) begin
		if (do_push)
			mem[wr_ptr] <= data_i;
	end

	// Show-ahead read port
	assign data_o  = mem[rd_ptr];
	assign empty_o = (level_q == '0);
	assign full_o  = (level_q == FULL_LEVEL);
	assign level_o = level_q;

endmodule

// File: verification/i2s_rx_checker.sv
`timescale 1ns/1ps

module i2s_rx_checker (
	input logic wbs_clk_i,
	input logic rst_i,
	input logic wbs_cyc_i,
	input logic wbs_stb_i,
	input logic wbs_ack_o,
	input logic sdma_req_o,
	input logic irq_dma_o
);

	// ------------------------------
	// Bus handshake
	// ------------------------------
	ack_one_cycle: assert property (@(posedge wbs_clk_i) disable iff (rst_i)
		wbs_ack_o |=> !wbs_ack_o)
		else $error("wbs_ack_o held longer than one cycle");

	ack_after_request: assert property (@(posedge wbs_clk_i) disable iff (rst_i)
		wbs_ack_o |-> $past(wbs_cyc_i & wbs_stb_i & ~wbs_ack_o))
		else $error("wbs_ack_o raised without a pending request");

	// Quiet outputs once reset has taken hold
	reset_quiet: assert property (@(posedge wbs_clk_i)
		rst_i && $past(rst_i) |-> !sdma_req_o && !irq_dma_o)
		else $error("DMA request or DMA interrupt active during reset");

endmodule

bind i2s_rx_dma_top i2s_rx_checker u_checker (
	.wbs_clk_i(wbs_clk_i), .rst_i(rst_i), .wbs_cyc_i(wbs_cyc_i), .wbs_stb_i(wbs_stb_i),
	.wbs_ack_o(wbs_ack_o), .sdma_req_o(sdma_req_o), .irq_dma_o(irq_dma_o)
);

// File: verification/tb_i2s_rx.sv
`timescale 1ns/1ps
`include "i2s_rx_params.svh"

module tb_i2s_rx;

	localparam int CLK_HALF_NS  = 20;
	localparam int SCK_DIV      = 8;                    // Bus clocks per I2S bit
	localparam int SLOT_BITS    = `I2S_SAMPLE_W + 1;    // Lead-in bit after each WS change
	localparam int FRAME_CYCLES = 2 * SLOT_BITS * SCK_DIV;
	localparam int TOTAL_FRAMES = 28;                   // Sent frames plus settling waits
	localparam int WATCHDOG_NS  = TOTAL_FRAMES * FRAME_CYCLES * 2 * CLK_HALF_NS + 20000;

	logic                  wbs_clk_i;
	logic                  rst_i;
	i2s_rx_pkg::reg_addr_t wbs_adr_i;
	logic                  wbs_cyc_i;
	logic                  wbs_stb_i;
	logic                  wbs_we_i;
	i2s_rx_pkg::wb_data_t  wbs_dat_i;
	i2s_rx_pkg::wb_data_t  wbs_dat_o;
	logic                  wbs_ack_o;
	logic                  i2s_sck_i;
	logic                  i2s_ws_i;
	logic                  i2s_din_i;
	logic                  irq_data_o;
	logic                  irq_dma_o;
	logic                  sdma_req_o;

	i2s_rx_pkg::sample_t   left_q [$];    // Model of the left FIFO
	i2s_rx_pkg::sample_t   right_q [$];
	logic [31:0]           lcg_state;
	i2s_rx_pkg::wb_data_t  value;
	int                    errors, errors_at_start, tests_run, tests_failed;
	int                    accesses, acks_seen, i;

	i2s_rx_dma_top UUT (.*);

	always #(CLK_HALF_NS) wbs_clk_i = ~wbs_clk_i;

	always @(negedge wbs_clk_i) begin
		if (wbs_ack_o)
			acks_seen++;
	end

	// ------------------------------
	// Stimulus helpers
	// ------------------------------
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic i2s_rx_pkg::wb_data_t status_word(input int size);
		i2s_rx_pkg::level_t lvl;
		lvl = i2s_rx_pkg::level_t'(size);
		return {25'd0, lvl, size == `I2S_FIFO_DEPTH, size == 0};
	endfunction

	// Level bits from the model and the sticky done bit from the caller
	function automatic i2s_rx_pkg::wb_data_t irq_sts_word(input logic done);
		return {29'd0, done, right_q.size() >= `I2S_IRQ_LEVEL, left_q.size() >= `I2S_IRQ_LEVEL};
	endfunction

	task automatic send_bit(input logic ws, input logic din);
		@(posedge wbs_clk_i);
		i2s_sck_i <= 1'b0;   // WS and data move on the falling edge
		i2s_ws_i  <= ws;
		i2s_din_i <= din;
		repeat (SCK_DIV / 2) @(posedge wbs_clk_i);
		i2s_sck_i <= 1'b1;
		repeat (SCK_DIV / 2 - 1) @(posedge wbs_clk_i);
	endtask

	task automatic send_frames(input int count, input logic capture);
		i2s_rx_pkg::sample_t word [2];
		logic [31:0]         rnd;
		int                  f, ch, b;
		for (f = 0; f < count; f++) begin
			rnd = lcg_next();
			word[0] = rnd[31:16];
			rnd = lcg_next();
			word[1] = rnd[31:16];
			for (ch = 0; ch < 2; ch++) begin
				send_bit(ch[0], 1'b0);   // WS change edge carries no data
				for (b = `I2S_SAMPLE_W - 1; b >= 0; b--)
					send_bit(ch[0], word[ch][b]);
			end
			if (capture) begin
				left_q.push_back(word[0]);
				right_q.push_back(word[1]);
			end
		end
		repeat (SCK_DIV) @(posedge wbs_clk_i);   // Last push lands within 4 cycles
	endtask

	// ------------------------------
	// Bus and check helpers
	// ------------------------------
	task automatic bus_access(input logic we, input i2s_rx_pkg::reg_addr_t adr,
	                          input i2s_rx_pkg::wb_data_t wdat,
	                          output i2s_rx_pkg::wb_data_t rdat);
		int waited;
		@(posedge wbs_clk_i);
		wbs_cyc_i <= 1'b1;
		wbs_stb_i <= 1'b1;
		wbs_we_i  <= we;
		wbs_adr_i <= adr;
		wbs_dat_i <= wdat;
		waited = 0;
		@(negedge wbs_clk_i);
		while (!wbs_ack_o && waited < 16) begin
			@(negedge wbs_clk_i);
			waited++;
		end
		assert (wbs_ack_o) else begin
			$display("Bus access to address %0h was never acknowledged", adr);
			errors++;
		end
		rdat = wbs_dat_o;
		accesses++;
		@(posedge wbs_clk_i);
		wbs_cyc_i <= 1'b0;   // Dropped as the ack cycle ends
		wbs_stb_i <= 1'b0;
		wbs_we_i  <= 1'b0;
	endtask

	task automatic check_value(input string what, input i2s_rx_pkg::wb_data_t exp,
	                           input i2s_rx_pkg::wb_data_t act);
		assert (act === exp) else begin
			$display("ERR %0d ns: %s expected %08h got %08h", $time, what, exp, act);
			errors++;
		end
	endtask

	task automatic write_reg(input i2s_rx_pkg::reg_addr_t adr, input i2s_rx_pkg::wb_data_t dat);
		i2s_rx_pkg::wb_data_t unused;
		bus_access(1'b1, adr, dat, unused);
	endtask

	task automatic read_check(input i2s_rx_pkg::reg_addr_t adr,
	                          input i2s_rx_pkg::wb_data_t exp, input string what);
		i2s_rx_pkg::wb_data_t rd;
		bus_access(1'b0, adr, 32'd0, rd);
		check_value(what, exp, rd);
	endtask

	task automatic wait_dma_request();
		int cycles;
		cycles = 0;
		@(negedge wbs_clk_i);
		while (!sdma_req_o && cycles < 64) begin
			@(negedge wbs_clk_i);
			cycles++;
		end
		assert (sdma_req_o) else begin
			$display("DMA request was not raised while stereo pairs were waiting");
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != errors_at_start)
			tests_failed++;
		$display("Test %0d %s: %s", tests_run, name, errors == errors_at_start ? "ok" : "failed");
		errors_at_start = errors;
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("FAIL: see errors above");
		$finish;
	end

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin
		wbs_clk_i = 1'b0;
		rst_i     = 1'b1;
		wbs_adr_i = '0;
		wbs_cyc_i = 1'b0;
		wbs_stb_i = 1'b0;
		wbs_we_i  = 1'b0;
		wbs_dat_i = '0;
		i2s_sck_i = 1'b0;
		i2s_ws_i  = 1'b1;
		i2s_din_i = 1'b0;
		lcg_state = 32'h5596;
		{errors, errors_at_start, tests_run, tests_failed, accesses, acks_seen} = '0;
		repeat (16) @(posedge wbs_clk_i);
		rst_i <= 1'b0;
		send_bit(1'b1, 1'b0);   // Park WS high so the first left slot is a change

		write_reg(`REG_EN, 32'd1);
		read_check(`REG_EN, 32'd1, "REG_EN set");
		write_reg(`REG_EN, 32'd0);
		read_check(`REG_EN, 32'd0, "REG_EN clear");
		value = lcg_next();
		write_reg(`REG_IRQ_EN, value);
		read_check(`REG_IRQ_EN, value & 32'h7, "REG_IRQ_EN");
		value = lcg_next();
		write_reg(`REG_DMA_CNT, value);
		read_check(`REG_DMA_CNT, value & 32'h1FF, "REG_DMA_CNT");
		read_check(9'h00C, `I2S_UNDEF_VALUE, "unmapped 0x00C");
		read_check(9'h1FF, `I2S_UNDEF_VALUE, "unmapped 0x1FF");
		check_value("ack count", i2s_rx_pkg::wb_data_t'(accesses),
		            i2s_rx_pkg::wb_data_t'(acks_seen));
		end_test("register access");

		write_reg(`REG_EN, 32'd1);
		send_frames(6, 1'b1);
		repeat (FRAME_CYCLES) @(posedge wbs_clk_i);
		read_check(`REG_LSTS, status_word(left_q.size()), "left status");
		read_check(`REG_RSTS, status_word(right_q.size()), "right status");
		while (left_q.size() > 0)
			read_check(`REG_LDAT, {16'd0, left_q.pop_front()}, "left sample");
		while (right_q.size() > 0)
			read_check(`REG_RDAT, {16'd0, right_q.pop_front()}, "right sample");
		write_reg(`REG_EN, 32'd0);
		send_frames(2, 1'b0);   // Receiver off so nothing is queued
		read_check(`REG_LSTS, status_word(left_q.size()), "left status disabled");
		read_check(`REG_RSTS, status_word(right_q.size()), "right status disabled");
		end_test("sample capture");

		write_reg(`REG_EN, 32'd1);
		send_frames(3, 1'b1);
		write_reg(`REG_FLUSH, 32'd1);
		left_q.delete();
		right_q.delete();
		read_check(`REG_LSTS, status_word(0), "left status after flush");
		read_check(`REG_RSTS, status_word(0), "right status after flush");
		read_check(`REG_LDAT, 32'd0, "empty left read");
		read_check(`REG_RDAT, 32'd0, "empty right read");
		end_test("flush and empty reads");

		write_reg(`REG_IRQ_EN, 32'd1);
		send_frames(8, 1'b1);
		@(negedge wbs_clk_i);
		check_value("irq_data_o at threshold", 32'd1, {31'd0, irq_data_o});
		read_check(`REG_IRQ_STS, irq_sts_word(1'b0), "IRQ status at threshold");
		write_reg(`REG_IRQ_EN, 32'd3);
		read_check(`REG_LDAT, {16'd0, left_q.pop_front()}, "left sample");
		read_check(`REG_IRQ_STS, irq_sts_word(1'b0), "IRQ status below left threshold");
		@(negedge wbs_clk_i);
		check_value("irq_data_o via right bit", 32'd1, {31'd0, irq_data_o});
		write_reg(`REG_IRQ_EN, 32'd1);
		@(negedge wbs_clk_i);
		check_value("irq_data_o right disabled", 32'd0, {31'd0, irq_data_o});
		write_reg(`REG_FLUSH, 32'd1);
		left_q.delete();
		right_q.delete();
		end_test("data interrupt");

		write_reg(`REG_IRQ_EN, 32'd4);
		send_frames(5, 1'b1);
		write_reg(`REG_DMA_CNT, 32'd5);
		write_reg(`REG_DMA_START, 32'd1);
		for (i = 0; i < 5; i++) begin
			wait_dma_request();
			read_check(`REG_DMA_DAT, {right_q.pop_front(), left_q.pop_front()}, "DMA pair");
		end
		read_check(`REG_DMA_STS, 32'd0, "DMA status after transfer");
		read_check(`REG_IRQ_STS, irq_sts_word(1'b1), "IRQ status DMA done");
		@(negedge wbs_clk_i);
		check_value("irq_dma_o after done", 32'd1, {31'd0, irq_dma_o});
		check_value("sdma_req_o after done", 32'd0, {31'd0, sdma_req_o});
		write_reg(`REG_IRQ_STS, 32'd4);
		read_check(`REG_IRQ_STS, irq_sts_word(1'b0), "IRQ status cleared");
		@(negedge wbs_clk_i);
		check_value("irq_dma_o cleared", 32'd0, {31'd0, irq_dma_o});
		end_test("DMA transfer");

		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule
